// File: pre_settings.svh
// frame geometry is fixed by the PE array column width; PRE_AW must cover PRE_ROWS*PRE_COLS
`ifndef PRE_SETTINGS_SVH
`define PRE_SETTINGS_SVH

////////////////////
// frame geometry
////////////////////
`define PRE_ROWS      24                       // pixel rows per frame
`define PRE_COLS      32                       // pixel columns per frame
`define PRE_PAD_COLS  (`PRE_COLS + 2)          // output columns incl. both edge pads
`define PRE_FRAME_PIX (`PRE_ROWS * `PRE_COLS)  // pixels held in one bank

////////////////////
// flow control and addressing
////////////////////
`define PRE_CREDITS   4                        // credits granted at reset
`define PRE_AW        10                       // pixel address within one bank

`endif

// File: pre_pkg.sv
// shared types only; column byte 0 is the top pad and the last byte is the bottom pad
`default_nettype none

`include "pre_settings.svh"

package pre_pkg;

  ////////////////////
  // reader FSM
  ////////////////////
  typedef enum logic [1:0] {
    IDLE,     // wait for a full bank
    GATHER,   // read one pixel column
    EMIT,     // hold column until a credit is free
    RELEASE   // hand the bank back to the writer
  } rd_state_e;

  typedef enum logic {
    BANK_A,
    BANK_B
  } bank_e;

  ////////////////////
  // output column
  ////////////////////
  localparam int COL_BYTES = `PRE_ROWS + 2;    // pad + pixels + pad

  typedef logic [COL_BYTES-1:0][7:0] column_t;  // 208 bits

endpackage

`default_nettype wire

// File: frame_if.sv
// rd_data follows rd_addr by one cycle; release_bank is a single-cycle pulse naming rd_bank
`timescale 1ns/1ps
`default_nettype none

`include "pre_settings.svh"

interface frame_if;
  import pre_pkg::*;

  logic [1:0]         full;          // one bit per bank, set when a frame lands
  logic [7:0]         rd_data;       // pixel at last cycle's rd_addr
  bank_e              rd_bank;       // bank the reader works on
  logic [`PRE_AW-1:0] rd_addr;       // row-major pixel address
  logic               release_bank;  // reader done with rd_bank

  // frame buffer side
  modport buf_mp (
    output full,
    output rd_data,
    input  rd_bank,
    input  rd_addr,
    input  release_bank
  );

  // column reader side
  modport rd_mp (
    input  full,
    input  rd_data,
    output rd_bank,
    output rd_addr,
    output release_bank
  );

endinterface

`default_nettype wire

// File: pingpong_frame_buffer.sv
// camera cannot stall; a frame starting on a still-full bank is dropped whole, o_overflow is registered
`timescale 1ns/1ps
`default_nettype none

`include "pre_settings.svh"

module pingpong_frame_buffer (
  input  wire        PEclk,
  input  wire        rst_n,
  input  wire  [7:0] i_pix,
  input  wire        i_pix_vld,
  frame_if.buf_mp    fb,
  output logic       o_overflow
);
  import pre_pkg::*;

  localparam int AW = `PRE_AW;

  logic [7:0]    mem_a [`PRE_FRAME_PIX];
  logic [7:0]    mem_b [`PRE_FRAME_PIX];

  bank_e         wr_bank;     // bank taking the current frame
  logic [AW-1:0] wr_addr;     // next pixel position in the frame
  logic          dropping;    // current frame is being discarded
  logic [1:0]    full_q;

  // one-cycle write pipeline
  logic          wr_en_q;
  logic [AW-1:0] wr_addr_q;
  bank_e         wr_bank_q;
  logic [7:0]    pix_q;
  logic          last_q;      // last pixel of a kept frame

  logic          first_pix;
  logic          last_pix;
  logic          drop_now;

  assign first_pix = (wr_addr == '0);
  assign last_pix  = (wr_addr == AW'(`PRE_FRAME_PIX - 1));
  assign drop_now  = first_pix ? full_q[wr_bank] : dropping;  // decided on pixel 0

  ////////////////////
  // write side
  ////////////////////
  always_ff @(posedge PEclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_bank    <= BANK_A;
      wr_addr    <= '0;
      dropping   <= 1'b0;
      wr_en_q    <= 1'b0;
      last_q     <= 1'b0;
      o_overflow <= 1'b0;
    end else begin
      wr_en_q    <= i_pix_vld && !drop_now;
      last_q     <= i_pix_vld && last_pix && !drop_now;
      o_overflow <= i_pix_vld && first_pix && full_q[wr_bank];
      if (i_pix_vld) begin
        wr_addr <= last_pix ? '0 : wr_addr + AW'(1);
        if (first_pix) dropping <= full_q[wr_bank];
        if (last_pix && !drop_now) begin
          wr_bank <= (wr_bank == BANK_A) ? BANK_B : BANK_A;  // frame complete
        end
      end
    end
  end

  always_ff @(posedge PEclk) begin
    wr_addr_q <= wr_addr;
    wr_bank_q <= wr_bank;
    pix_q     <= i_pix;
  end

  always_ff @(posedge PEclk) begin
    if (wr_en_q) begin
      if (wr_bank_q == BANK_A) mem_a[wr_addr_q] <= pix_q;
      else                     mem_b[wr_addr_q] <= pix_q;
    end
  end

  // full rises with the last write, falls on the reader's release
  always_ff @(posedge PEclk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 2'b00;
    end else begin
      for (int b = 0; b < 2; b++) begin
        if (last_q && wr_bank_q == bank_e'(b)) full_q[b] <= 1'b1;
        else if (fb.release_bank && fb.rd_bank == bank_e'(b)) full_q[b] <= 1'b0;
      end
    end
  end

  assign fb.full = full_q;

  ////////////////////
  // read side
  ////////////////////
  always_ff @(posedge PEclk) begin
    fb.rd_data <= (fb.rd_bank == BANK_A) ? mem_a[fb.rd_addr] : mem_b[fb.rd_addr];
  end

  // a kept frame must never land on a bank the reader still owns
  a_no_write_full: assert property (@(posedge PEclk) disable iff (!rst_n)
    wr_en_q |-> !full_q[wr_bank_q]);

  // reader may only hand back a bank that was filled
  a_release_full: assert property (@(posedge PEclk) disable iff (!rst_n)
    fb.release_bank |-> full_q[fb.rd_bank]);

endmodule

`default_nettype wire

// File: column_padder.sv
// pad byte is sampled once per frame in IDLE; i_credit_ret must never exceed columns received
`timescale 1ns/1ps
`default_nettype none

`include "pre_settings.svh"

module column_padder (
  input  wire              PEclk,
  input  wire              rst_n,
  input  wire  [7:0]       i_pad,
  frame_if.rd_mp           fr,
  input  wire              i_credit_ret,
  output pre_pkg::column_t o_col,
  output logic             o_col_vld,
  output logic             o_frame_done
);
  import pre_pkg::*;

  localparam int AW = `PRE_AW;
  localparam int CW = $clog2(`PRE_CREDITS + 1);

  rd_state_e     state;
  bank_e         rd_bank;
  logic [5:0]    col_cnt;      // output column 0..33
  logic [4:0]    row_cnt;      // gather step 0..24
  logic [7:0]    pad_q;        // this frame's pad byte
  logic [CW-1:0] credits;
  column_t       col_buf;

  logic          spend;
  logic          last_col;
  logic          next_edge;    // next column is the right pad column
  logic          gathering;

  assign spend     = (state == EMIT) && (credits != '0);
  assign last_col  = (col_cnt == 6'(`PRE_PAD_COLS - 1));
  assign next_edge = (col_cnt == 6'(`PRE_PAD_COLS - 2));
  assign gathering = (state == GATHER) && (row_cnt < 5'(`PRE_ROWS));

  ////////////////////
  // interface drive
  ////////////////////
  assign fr.rd_bank      = rd_bank;
  assign fr.release_bank = (state == RELEASE);
  // pixel (r, c-1) sits at r*32 + c-1
  assign fr.rd_addr = gathering ?
                      AW'(row_cnt) * AW'(`PRE_COLS) + AW'(col_cnt) - AW'(1) : '0;

  assign o_col        = col_buf;
  assign o_col_vld    = spend;
  assign o_frame_done = spend && last_col;

  ////////////////////
  // reader FSM
  ////////////////////
  always_ff @(posedge PEclk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      rd_bank <= BANK_A;
      col_cnt <= '0;
      row_cnt <= '0;
      pad_q   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (fr.full[rd_bank]) begin
            pad_q   <= i_pad;
            col_cnt <= '0;
            state   <= EMIT;      // column 0 is pads only
          end
        end
        GATHER: begin
          row_cnt <= row_cnt + 5'd1;
          if (row_cnt == 5'(`PRE_ROWS)) state <= EMIT;  // last byte captured
        end
        EMIT: begin
          if (spend) begin
            if (last_col) begin
              state <= RELEASE;
            end else begin
              col_cnt <= col_cnt + 6'd1;
              row_cnt <= '0;
              if (!next_edge) state <= GATHER;
            end
          end
        end
        RELEASE: begin
          rd_bank <= (rd_bank == BANK_A) ? BANK_B : BANK_A;  // alternate banks
          state   <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // column assembly; byte r+1 gets the read issued one step earlier
  always_ff @(posedge PEclk) begin
    case (state)
      IDLE: col_buf <= {COL_BYTES{i_pad}};
      GATHER: begin
        if (row_cnt == '0) begin
          col_buf[0]             <= pad_q;
          col_buf[COL_BYTES - 1] <= pad_q;
        end else begin
          col_buf[row_cnt] <= fr.rd_data;
        end
      end
      EMIT: if (spend && next_edge) col_buf <= {COL_BYTES{pad_q}};
      default: ;
    endcase
  end

  ////////////////////
  // credit counter
  ////////////////////
  always_ff @(posedge PEclk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= CW'(`PRE_CREDITS);
    end else begin
      credits <= credits - CW'(spend) + CW'(i_credit_ret);
    end
  end

  // downstream returns no more than it received
  a_credit_max: assert property (@(posedge PEclk) disable iff (!rst_n)
    credits <= CW'(`PRE_CREDITS));

endmodule

`default_nettype wire

// File: input_pre_top.sv
// single clock PEclk; pixels arrive row-major and cannot be stalled, columns leave under credits
`timescale 1ns/1ps
`default_nettype none

module input_pre_top (
  input  wire              PEclk,
  input  wire              rst_n,
  // camera pixels
  input  wire  [7:0]       i_pix,
  input  wire              i_pix_vld,
  input  wire  [7:0]       i_pad,          // padding byte
  // PE array columns
  input  wire              i_credit_ret,
  output pre_pkg::column_t o_col,
  output logic             o_col_vld,
  // status
  output logic             o_frame_done,
  output logic             o_overflow
);

  frame_if fb ();

  pingpong_frame_buffer u_buf (
    .PEclk      (PEclk),
    .rst_n      (rst_n),
    .i_pix      (i_pix),
    .i_pix_vld  (i_pix_vld),
    .fb         (fb.buf_mp),
    .o_overflow (o_overflow)
  );

  column_padder u_pad (
    .PEclk        (PEclk),
    .rst_n        (rst_n),
    .i_pad        (i_pad),
    .fr           (fb.rd_mp),
    .i_credit_ret (i_credit_ret),
    .o_col        (o_col),
    .o_col_vld    (o_col_vld),
    .o_frame_done (o_frame_done)
  );

endmodule

`default_nettype wire

// File: tb_checker.sv
// compares every o_col against columns rebuilt from the test values; outputs outside a test are errors
`timescale 1ns/1ps
`default_nettype none

`include "pre_settings.svh"

module tb_checker (
  input  wire              PEclk,
  input  wire              rst_n,
  input  pre_pkg::column_t o_col,
  input  wire              o_col_vld,
  input  wire              o_frame_done,
  input  wire              o_overflow,
  input  wire              i_credit_ret,
  input  wire  [63:0]      t_name,
  input  wire  [7:0]       t_base,
  input  wire  [7:0]       t_step,
  input  wire  [7:0]       t_pad,
  input  wire  [31:0]      t_frames,
  input  wire              t_start,      // one-cycle pulse
  input  wire              t_end,        // one-cycle pulse
  output int               frames_seen,
  output int               tests_pass,
  output int               tests_fail
);
  import pre_pkg::*;

  bit active;
  int col_idx;
  int ovf_cnt;
  int outstanding;
  int errs;
  int exp_frames;

  // pixel (r, c) of frame f, frame index shifts the pattern so a dropped frame shows
  function automatic logic [7:0] pixel_value(int f, int r, int c);
    int idx;
    idx = r * `PRE_COLS + c;
    return 8'(int'(t_base) + int'(t_step) * idx + 17 * f);
  endfunction

  function automatic column_t expect_col(int f, int c);
    column_t col;
    for (int b = 0; b < COL_BYTES; b++) col[b] = t_pad;
    if (c > 0 && c < `PRE_PAD_COLS - 1) begin
      for (int r = 0; r < `PRE_ROWS; r++) col[r+1] = pixel_value(f, r, c - 1);
    end
    return col;
  endfunction

  initial begin
    frames_seen = 0;
    tests_pass  = 0;
    tests_fail  = 0;
    active      = 0;
    outstanding = 0;
  end

  always @(posedge PEclk) begin
    column_t exp_c;
    if (rst_n) begin
      outstanding = outstanding + int'(o_col_vld) - int'(i_credit_ret);
      if (outstanding > `PRE_CREDITS) begin
        $display("test %0s has %0d columns without credit", t_name, outstanding);
        errs++;
      end
      if (t_start) begin
        active      = 1;
        col_idx     = 0;
        ovf_cnt     = 0;
        errs        = 0;
        frames_seen = 0;
        exp_frames  = (t_frames > 2) ? 2 : int'(t_frames);  // third frame overflows
      end else if (!active && (o_col_vld || o_frame_done || o_overflow)) begin
        $display("DUT output active while no test is running");
        tests_fail++;
      end
      if (active) begin
        if (o_overflow) ovf_cnt++;
        if (o_col_vld) begin
          exp_c = expect_col(frames_seen, col_idx);
          if (o_col !== exp_c) begin
            $display("Mismatch %0s expected %h actual %h", t_name, exp_c, o_col);
            errs++;
          end
          if (o_frame_done != (col_idx == `PRE_PAD_COLS - 1)) begin
            $display("test %0s frame done at column %0d", t_name, col_idx);
            errs++;
          end
          col_idx++;
        end
        if (o_frame_done) begin
          frames_seen++;
          col_idx = 0;
        end
      end
      if (t_end) begin
        active = 0;
        if (frames_seen != exp_frames) begin
          $display("Mismatch %0s expected %0d actual %0d", t_name, exp_frames, frames_seen);
          errs++;
        end
        if (ovf_cnt != ((t_frames > 2) ? 1 : 0)) begin
          $display("Mismatch %0s expected %0d actual %0d", t_name, (t_frames > 2), ovf_cnt);
          errs++;
        end
        $display("test %0s finished, %0d frames, %0d overflow, %0d errors",
                 t_name, frames_seen, ovf_cnt, errs);
        if (errs == 0) tests_pass++;
        else           tests_fail++;
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_input_pre.sv
// tests come from pre_tests.dat; frames of one test are sent back to back, tests run one at a time
`timescale 1ns/1ps
`default_nettype none

`include "pre_settings.svh"

module tb_input_pre;
  import pre_pkg::*;

  logic       PEclk;
  logic       rst_n;
  logic [7:0] i_pix;
  logic       i_pix_vld;
  logic [7:0] i_pad;
  logic       i_credit_ret;
  column_t    o_col;
  logic       o_col_vld;
  logic       o_frame_done;
  logic       o_overflow;

  logic [63:0] t_name;
  logic [7:0]  t_base;
  logic [7:0]  t_step;
  logic [7:0]  t_pad;
  logic [31:0] t_frames;
  logic        t_start;
  logic        t_end;
  int          t_delay;
  int          frames_seen;
  int          tests_pass;
  int          tests_fail;

  longint      cycle;
  longint      due_q[$];     // cycles at which credits go back
  logic        hold_credits; // downstream returns nothing while set

  input_pre_top UUT (.*);

  tb_checker u_chk (.*);

  initial begin
    PEclk = 0;
    forever #2 PEclk = ~PEclk;
  end

  ////////////////////
  // credit returner
  ////////////////////
  always @(posedge PEclk) begin
    cycle++;
    if (o_col_vld) due_q.push_back(cycle + t_delay + $urandom_range(3, 0));
    #1;
    i_credit_ret = !hold_credits && (due_q.size() > 0 && due_q[0] <= cycle);
    if (i_credit_ret) void'(due_q.pop_front());
  end

  task automatic send_frame(int f);
    for (int i = 0; i < `PRE_FRAME_PIX; i++) begin
      @(posedge PEclk);
      #1;
      i_pix     = 8'(int'(t_base) + int'(t_step) * i + 17 * f);
      i_pix_vld = 1;
    end
    @(posedge PEclk);
    #1;
    i_pix_vld = 0;
  endtask

  task automatic timeout_fail(string what);
    $display("test %0s timed out waiting for %0s", t_name, what);
    $display("ERRORS FOUND");
    $finish;
  endtask

  initial begin
    int fd;
    int n;
    int waited;
    int exp;
    reg [8*128-1:0] line;
    void'($urandom(73));
    cycle = 0;
    rst_n = 0;
    i_pix = 0;
    i_pix_vld = 0;
    i_pad = 0;
    i_credit_ret = 0;
    hold_credits = 0;
    t_name = "none";
    t_base = 0;
    t_step = 0;
    t_pad = 0;
    t_frames = 0;
    t_start = 0;
    t_end = 0;
    t_delay = 0;
    repeat (10) @(posedge PEclk);
    #1 rst_n = 1;
    repeat (20) @(posedge PEclk);  // quiet window, checker flags any output
    fd = $fopen("pre_tests.dat", "r");
    if (fd == 0) begin
      $display("cannot open pre_tests.dat");
      $display("ERRORS FOUND");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = 0;
        void'($fgets(line, fd));
        n = $sscanf(line, "%s %h %h %h %d %d", t_name, t_base, t_step, t_pad, t_frames, t_delay);
        if (n == 6) begin
          i_pad = t_pad;
          @(posedge PEclk);
          hold_credits = (t_frames > 2);  // overflow case stalls the reader
          #1 t_start = 1;
          @(posedge PEclk);
          #1 t_start = 0;
          for (int f = 0; f < t_frames; f++) send_frame(f);
          @(posedge PEclk);
          hold_credits = 0;               // credits resume
          exp = (t_frames > 2) ? 2 : int'(t_frames);
          waited = 0;
          while (frames_seen < exp) begin
            @(posedge PEclk);
            waited++;
            if (waited > 50000) timeout_fail("frame done");
          end
          waited = 0;
          while (due_q.size() > 0 || i_credit_ret) begin
            @(posedge PEclk);
            waited++;
            if (waited > 1000) timeout_fail("credit returns");
          end
          repeat (4) @(posedge PEclk);
          #1 t_end = 1;
          @(posedge PEclk);
          #1 t_end = 0;
        end
      end
      $fclose(fd);
      repeat (4) @(posedge PEclk);
      $display("tests passed %0d, failed %0d", tests_pass, tests_fail);
      if (tests_fail == 0 && tests_pass > 0) begin
        $display("NO ERRORS");
      end else begin
        $display("ERRORS FOUND");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: pre_tests.dat
# name base(hex) step(hex) pad(hex) frames credit_delay
# pixel = base + step*(r*32+c) + 17*frame_index, modulo 256
t1 00 01 aa 1 2
t2 10 03 55 1 0
t3 7f 05 3c 1 40
t4 20 07 c3 2 1
t5 01 02 e1 3 30

// File: filelist.f
+incdir+.
pre_pkg.sv
frame_if.sv
pingpong_frame_buffer.sv
column_padder.sv
input_pre_top.sv
tb_checker.sv
tb_input_pre.sv

// File: run_sim.sh
#!/bin/sh
# build and run with Verilator, fail if the log reports errors
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module tb_input_pre \
  -f filelist.f -o tb_input_pre
./obj_dir/tb_input_pre > sim.log 2>&1 || true
cat sim.log
if grep -q "ERRORS FOUND" sim.log; then
  exit 1
fi
grep -q "NO ERRORS" sim.log
